// ==== hw/icd2_pkg.sv ====
package icd2_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  typedef logic [7:0]  byte_t;       // bus data, registers, pads, packet bytes
  typedef logic [23:0] snes_addr_t;  // cartridge bus address
  typedef logic [8:0]  row_addr_t;   // [8:4] tile column, [3:1] line, [0] bitplane
  typedef logic [1:0]  row_sel_t;    // one of four row buffers
  typedef logic [4:0]  char_row_t;   // character row counter
  typedef logic [1:0]  pixel_t;      // handheld 2-bit shade
  typedef logic [1:0]  p1_t;         // select lines from the handheld
  typedef logic [3:0]  nibble_t;     // joypad answer
  typedef logic [1:0]  pad_id_t;     // current player
  typedef logic [6:0]  bit_pos_t;    // 128 packet bits

  // serial receive FSM, one-hot
  typedef enum logic [3:0] {
    IDLE = 4'b0001,
    RECV = 4'b0010,
    WAIT = 4'b0100,
    END  = 4'b1000   // encoding slot only, never entered
  } btn_state_t;

  // ----------------------------------------------------------------------
  // counts
  // ----------------------------------------------------------------------
  localparam int ROW_CNT   = 4;
  localparam int PAD_CNT   = 4;
  localparam int PKT_BYTES = 16;

  // register window, compared against {a[22], a[15:11], 7'h00, a[3:0]}
  localparam logic [15:0] REG_LCDCHW   = 16'h6000;  // R  char row / write row
  localparam logic [15:0] REG_LCDCHR   = 16'h6001;  // W  read row select
  localparam logic [15:0] REG_PKTRDY   = 16'h6002;  // R  packet ready
  localparam logic [15:0] REG_CTL      = 16'h6003;  // W  control
  localparam logic [15:0] REG_PAD0     = 16'h6004;  // W  pads at 6004..6007
  localparam logic [15:0] REG_VER      = 16'h600F;  // R  version
  localparam logic [15:0] REG_PKT_BASE = 16'h7000;  // R  packet at 7000..700F
  localparam logic [15:0] REG_CHDAT    = 16'h7800;  // R  row buffer data

  // reset values
  localparam byte_t VERSION_VAL  = 8'h61;
  localparam byte_t CTL_RESET    = 8'h01;  // bit 7 low holds the cpu in reset
  localparam byte_t PAD_RELEASED = 8'hFF;  // active low buttons

endpackage

// ==== hw/row_buffers.sv ====
`timescale 1ns/100ps

module row_buffers #(
  parameter int ROW_BYTES = 512
) (
  input  logic                CLK,
  input  logic                wr_en,
  input  icd2_pkg::row_sel_t  wr_row,
  input  icd2_pkg::row_addr_t wr_addr,
  input  icd2_pkg::byte_t     wr_data,
  input  icd2_pkg::row_sel_t  rd_row,
  input  icd2_pkg::row_addr_t rd_addr,
  output icd2_pkg::byte_t     rd_data
);
  import icd2_pkg::*;

  byte_t    rd_q [ROW_CNT];  // registered read of every buffer
  row_sel_t rd_row_q;        // row select aligned with rd_q

  for (genvar g = 0; g < ROW_CNT; g++) begin : g_row
    byte_t mem [ROW_BYTES];  // one scanline buffer

    always_ff @(posedge CLK) begin
      if (wr_en && (wr_row == row_sel_t'(g)) && (int'(wr_addr) < ROW_BYTES)) begin
        mem[wr_addr] <= wr_data;
      end
      // addresses past a short buffer read as zero
      rd_q[g] <= (int'(rd_addr) < ROW_BYTES) ? mem[rd_addr] : '0;
    end
  end

  always_ff @(posedge CLK) begin
    rd_row_q <= rd_row;
  end

  assign rd_data = rd_q[rd_row_q];  // one cycle after address and row

endmodule

// ==== hw/pixel_packer.sv ====
`timescale 1ns/100ps

module pixel_packer (
  input  logic                CLK,
  input  logic                cpu_ireset_r,
  input  logic                ppu_dot_edge,     // one cycle per handheld dot
  input  logic                ppu_pixel_valid,
  input  icd2_pkg::pixel_t    ppu_pixel,
  input  logic                ppu_vsync_edge,
  input  logic                ppu_hsync_edge,
  output icd2_pkg::byte_t     lcdc_status,
  output logic                wr_en,
  output icd2_pkg::row_sel_t  wr_row,
  output icd2_pkg::row_addr_t wr_addr,
  output icd2_pkg::byte_t     wr_data
);
  import icd2_pkg::*;

  localparam char_row_t LAST_CHAR_ROW = 5'd18;  // 144 lines / 8

  row_addr_t  pos_r;        // column and line being filled, bit 0 unused
  logic [2:0] pix_idx_r;    // pixel within the 8 pixel group
  byte_t      plane_r [2];  // planar bytes under construction
  logic [1:0] wr_pipe_r;    // [0] plane 0 write, [1] plane 1 write
  row_addr_t  wr_base_r;    // column/line of the finished group
  char_row_t  char_row_r;
  row_sel_t   row_r;        // buffer being written

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------
  assign lcdc_status = {char_row_r, 1'b0, row_r};
  assign wr_en       = |wr_pipe_r;
  assign wr_row      = row_r;
  assign wr_addr     = {wr_base_r[8:1], wr_pipe_r[1]};  // plane picks bit 0
  assign wr_data     = plane_r[wr_pipe_r[1]];

  // ----------------------------------------------------------------------
  // position counters
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      pos_r      <= '0;
      pix_idx_r  <= '0;
      wr_pipe_r  <= '0;
      char_row_r <= '0;
      row_r      <= '0;
    end else begin
      wr_pipe_r <= {wr_pipe_r[0], 1'b0};  // plane 0 then plane 1

      if (ppu_dot_edge) begin
        if (ppu_pixel_valid) begin
          pix_idx_r <= pix_idx_r + 3'd1;
          if (&pix_idx_r) begin
            pos_r[8:4]   <= pos_r[8:4] + 5'd1;  // next tile column
            wr_pipe_r[0] <= 1'b1;
          end
        end else if (ppu_vsync_edge) begin
          pos_r[8:4] <= '0;
          pix_idx_r  <= '0;
          char_row_r <= '0;  // line and write row carry over
        end else if (ppu_hsync_edge) begin
          if (char_row_r != LAST_CHAR_ROW) begin
            pos_r[3:1] <= pos_r[3:1] + 3'd1;
            pos_r[8:4] <= '0;
            if (pos_r[3:1] == 3'd7) begin
              row_r      <= row_r + 2'd1;  // wraps over four buffers
              char_row_r <= char_row_r + 5'd1;
            end
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // pixel data
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (ppu_dot_edge && ppu_pixel_valid) begin
      // msb first, shade bit 0 to plane 0, bit 1 to plane 1
      {plane_r[1][~pix_idx_r], plane_r[0][~pix_idx_r]} <= ppu_pixel;
      if (&pix_idx_r) wr_base_r <= pos_r;
    end
  end

  // plane bytes must hold until both planes of a group are written
  a_planes_stable: assert property (
    @(posedge CLK) disable iff (cpu_ireset_r) wr_en |-> !(ppu_dot_edge && ppu_pixel_valid)
  );

endmodule

// ==== hw/joypad_serial.sv ====
`timescale 1ns/100ps

module joypad_serial (
  input  logic               CLK,
  input  logic               cpu_ireset_r,
  input  logic               cpu_edge,      // handheld cpu clock strobe
  input  icd2_pkg::p1_t      p1i,           // select lines, also serial data
  input  icd2_pkg::byte_t    pads [icd2_pkg::PAD_CNT],
  input  icd2_pkg::pad_id_t  player_mask,
  input  logic               pktrdy_clear,
  output icd2_pkg::nibble_t  p1o,
  output logic               idl,
  output icd2_pkg::byte_t    pkt [icd2_pkg::PKT_BYTES],
  output logic               pktrdy
);
  import icd2_pkg::*;

  btn_state_t state_r;
  btn_state_t state_next_r;  // where WAIT goes on a good handshake
  p1_t        prev_r;        // last sampled select value
  pad_id_t    id_r;
  bit_pos_t   bit_pos_r;

  logic p1_change;   // select lines moved on this cpu edge
  logic wait_match;  // value WAIT is looking for
  logic pkt_set;     // terminating 10 seen

  // ----------------------------------------------------------------------
  // joypad answer
  // ----------------------------------------------------------------------
  always_comb begin
    case (p1i)
      2'b11:   p1o = ~{2'b00, id_r};     // F,E,D,C for players 0..3
      2'b01:   p1o = pads[id_r][7:4];   // buttons
      2'b10:   p1o = pads[id_r][3:0];   // d-pad
      default: p1o = '0;
    endcase
  end

  assign idl        = (state_r == IDLE);
  assign p1_change  = cpu_edge && (p1i != prev_r);
  // 11 between bits, 10 once all 128 bits are in
  assign wait_match = (p1i == {1'b1, state_next_r != IDLE});
  assign pkt_set    = p1_change && (p1i != 2'b00) && (state_r == WAIT) &&
                      wait_match && (state_next_r == IDLE);

  // ----------------------------------------------------------------------
  // serial receive FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      state_r      <= IDLE;
      state_next_r <= IDLE;
      prev_r       <= 2'b00;
      id_r         <= '0;
      bit_pos_r    <= '0;
      pktrdy       <= 1'b0;
      for (int i = 0; i < PKT_BYTES; i++) begin
        pkt[i] <= '0;
      end
    end else begin
      if (cpu_edge) prev_r <= p1i;

      if (p1_change) begin
        if (p1i == 2'b00) begin
          // any move to 00 starts a packet, even mid transfer
          bit_pos_r    <= '0;
          state_next_r <= RECV;
          state_r      <= WAIT;
        end else begin
          case (state_r)
            IDLE: begin
              if (!prev_r[1] && p1i[1]) id_r <= (id_r + 2'd1) & player_mask;  // next player
            end
            RECV: begin
              if (^p1i) begin  // 11 is a no-op here
                pkt[bit_pos_r[6:3]][bit_pos_r[2:0]] <= p1i[0];  // lsb first
                bit_pos_r    <= bit_pos_r + 7'd1;
                state_next_r <= (&bit_pos_r) ? WAIT : RECV;
                state_r      <= WAIT;
              end
            end
            WAIT: begin
              if (wait_match) begin
                state_r      <= state_next_r;
                state_next_r <= IDLE;
              end else if (^p1i) begin
                state_r <= IDLE;  // stray 01/10, drop the packet
              end
            end
            default: state_r <= IDLE;
          endcase
        end
      end

      pktrdy <= (pktrdy & ~pktrdy_clear) | pkt_set;
    end
  end

  a_no_end: assert property (
    @(posedge CLK) disable iff (cpu_ireset_r) state_r != END
  );

endmodule

// ==== hw/icd2_regs.sv ====
`timescale 1ns/100ps

module icd2_regs (
  input  logic                 CLK,
  input  logic                 cpu_ireset_r,
  input  logic                 snes_rd_start,  // one cycle, start of bus read
  input  logic                 snes_wr_end,    // one cycle, end of bus write
  input  icd2_pkg::snes_addr_t snes_addr,
  input  icd2_pkg::byte_t      data_in,
  output icd2_pkg::byte_t      data_out,
  output logic                 cpu_rst,
  input  icd2_pkg::byte_t      lcdc_status,
  input  icd2_pkg::byte_t      pkt [icd2_pkg::PKT_BYTES],
  input  logic                 pktrdy,
  input  icd2_pkg::byte_t      rd_data,
  output icd2_pkg::byte_t      pads [icd2_pkg::PAD_CNT],
  output icd2_pkg::pad_id_t    player_mask,
  output logic                 pktrdy_clear,
  output icd2_pkg::row_sel_t   rd_row,
  output icd2_pkg::row_addr_t  rd_addr
);
  import icd2_pkg::*;

  byte_t       ctl_r;    // [7] run, [5:4] players, [1:0] clock divisor
  byte_t       chdat_r;  // row buffer byte, one cycle behind rd_data
  logic [16:0] dec_key;  // compact form of the bus address

  // ----------------------------------------------------------------------
  // address decode
  // ----------------------------------------------------------------------
  logic hit_lcdchw;
  logic hit_lcdchr;
  logic hit_pktrdy;
  logic hit_ctl;
  logic hit_ver;
  logic hit_pkt;
  logic hit_chdat;

  assign dec_key    = {snes_addr[22], snes_addr[15:11], 7'h00, snes_addr[3:0]};
  assign hit_lcdchw = (dec_key == {1'b0, REG_LCDCHW});
  assign hit_lcdchr = (dec_key == {1'b0, REG_LCDCHR});
  assign hit_pktrdy = (dec_key == {1'b0, REG_PKTRDY});
  assign hit_ctl    = (dec_key == {1'b0, REG_CTL});
  assign hit_ver    = (dec_key == {1'b0, REG_VER});
  assign hit_pkt    = (dec_key[16:4] == {1'b0, REG_PKT_BASE[15:4]});  // 16 byte block
  assign hit_chdat  = (dec_key == {1'b0, REG_CHDAT});

  assign cpu_rst     = ~ctl_r[7];
  assign player_mask = ctl_r[5:4];  // 0: one player, 1: two, 3: four

  // ----------------------------------------------------------------------
  // control state
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      ctl_r        <= CTL_RESET;
      rd_row       <= '0;
      rd_addr      <= '0;
      pktrdy_clear <= 1'b0;
      for (int i = 0; i < PAD_CNT; i++) begin
        pads[i] <= PAD_RELEASED;
      end
    end else begin
      pktrdy_clear <= 1'b0;

      // pads beyond the enabled player count read as released
      case (player_mask)
        2'd0: for (int i = 1; i < PAD_CNT; i++) pads[i] <= PAD_RELEASED;
        2'd1: for (int i = 2; i < PAD_CNT; i++) pads[i] <= PAD_RELEASED;
        default: ;
      endcase

      if (snes_wr_end) begin
        if (hit_lcdchr) begin
          rd_row  <= data_in[1:0];  // new read row, restart at byte 0
          rd_addr <= '0;
        end
        if (hit_ctl) begin
          ctl_r <= {data_in[7], 1'b0, data_in[5:4], 2'b00, data_in[1:0]};
        end
        for (int i = 0; i < PAD_CNT; i++) begin
          if (dec_key == {1'b0, REG_PAD0 + 16'(i)}) pads[i] <= data_in;  // later write wins
        end
      end

      if (snes_rd_start) begin
        if (hit_chdat) rd_addr <= rd_addr + 1'b1;  // auto increment per byte
        if (hit_pkt && (snes_addr[3:0] == 4'h0)) pktrdy_clear <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // read data
  // ----------------------------------------------------------------------
  // latched at read start so a write later in the same bus cycle
  // cannot move the value under the console
  always_ff @(posedge CLK) begin
    chdat_r <= rd_data;
    if (snes_rd_start) begin
      if (hit_lcdchw)      data_out <= lcdc_status;
      else if (hit_pktrdy) data_out <= {7'd0, pktrdy};
      else if (hit_ver)    data_out <= VERSION_VAL;
      else if (hit_pkt)    data_out <= pkt[snes_addr[3:0]];
      else if (hit_chdat)  data_out <= chdat_r;
    end
  end

  // the joypad side sees clear as a single pulse per 7000 read
  a_clear_pulse: assert property (
    @(posedge CLK) disable iff (cpu_ireset_r) pktrdy_clear |=> !pktrdy_clear
  );

endmodule

// ==== hw/icd2_top.sv ====
`timescale 1ns/100ps

module icd2_top #(
  parameter int ROW_BYTES = 512
) (
  input  logic                  CLK,
  input  logic                  cpu_ireset_r,
  // cartridge bus
  input  logic                  snes_rd_start,
  input  logic                  snes_wr_end,
  input  icd2_pkg::snes_addr_t  snes_addr,
  input  icd2_pkg::byte_t       data_in,
  output icd2_pkg::byte_t       data_out,
  output logic                  cpu_rst,
  // handheld pixel stream
  input  logic                  ppu_dot_edge,
  input  logic                  ppu_pixel_valid,
  input  icd2_pkg::pixel_t      ppu_pixel,
  input  logic                  ppu_vsync_edge,
  input  logic                  ppu_hsync_edge,
  // joypad / serial
  input  logic                  cpu_edge,
  input  icd2_pkg::p1_t         p1i,
  output icd2_pkg::nibble_t     p1o,
  output logic                  idl
);
  import icd2_pkg::*;

  // ----------------------------------------------------------------------
  // internal nets
  // ----------------------------------------------------------------------
  byte_t     lcdc_status;            // packer -> regs
  logic      wr_en;                  // packer -> row buffers
  row_sel_t  wr_row;
  row_addr_t wr_addr;
  byte_t     wr_data;
  row_sel_t  rd_row;                 // regs -> row buffers
  row_addr_t rd_addr;
  byte_t     rd_data;                // row buffers -> regs
  byte_t     pads [PAD_CNT];         // regs -> joypad
  pad_id_t   player_mask;
  logic      pktrdy_clear;
  byte_t     pkt [PKT_BYTES];        // joypad -> regs
  logic      pktrdy;

  icd2_regs i_regs (
    .CLK           (CLK),
    .cpu_ireset_r  (cpu_ireset_r),
    .snes_rd_start (snes_rd_start),
    .snes_wr_end   (snes_wr_end),
    .snes_addr     (snes_addr),
    .data_in       (data_in),
    .data_out      (data_out),
    .cpu_rst       (cpu_rst),
    .lcdc_status   (lcdc_status),
    .pkt           (pkt),
    .pktrdy        (pktrdy),
    .rd_data       (rd_data),
    .pads          (pads),
    .player_mask   (player_mask),
    .pktrdy_clear  (pktrdy_clear),
    .rd_row        (rd_row),
    .rd_addr       (rd_addr)
  );

  pixel_packer i_packer (
    .CLK             (CLK),
    .cpu_ireset_r    (cpu_ireset_r),
    .ppu_dot_edge    (ppu_dot_edge),
    .ppu_pixel_valid (ppu_pixel_valid),
    .ppu_pixel       (ppu_pixel),
    .ppu_vsync_edge  (ppu_vsync_edge),
    .ppu_hsync_edge  (ppu_hsync_edge),
    .lcdc_status     (lcdc_status),
    .wr_en           (wr_en),
    .wr_row          (wr_row),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data)
  );

  row_buffers #(.ROW_BYTES(ROW_BYTES)) i_rows (
    .CLK     (CLK),
    .wr_en   (wr_en),
    .wr_row  (wr_row),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_row  (rd_row),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  joypad_serial i_joy (
    .CLK          (CLK),
    .cpu_ireset_r (cpu_ireset_r),
    .cpu_edge     (cpu_edge),
    .p1i          (p1i),
    .pads         (pads),
    .player_mask  (player_mask),
    .pktrdy_clear (pktrdy_clear),
    .p1o          (p1o),
    .idl          (idl),
    .pkt          (pkt),
    .pktrdy       (pktrdy)
  );

endmodule

// ==== tb/icd2_tb.sv ====
`timescale 1ns/100ps

module icd2_tb;
  import icd2_pkg::*;

  localparam int LINES      = 8;            // one character row of scanlines
  localparam int TILES      = 20;           // tiles per scanline
  localparam int ROW_PIX    = TILES * 8;
  localparam int PKT_BITS   = PKT_BYTES * 8;
  localparam int MAX_CYCLES = 60000;        // run needs ~7.5k, mostly the pixel stream

  logic       CLK;
  logic       cpu_ireset_r;
  logic       snes_rd_start;
  logic       snes_wr_end;
  snes_addr_t snes_addr;
  byte_t      data_in;
  byte_t      data_out;
  logic       cpu_rst;
  logic       ppu_dot_edge;
  logic       ppu_pixel_valid;
  pixel_t     ppu_pixel;
  logic       ppu_vsync_edge;
  logic       ppu_hsync_edge;
  logic       cpu_edge;
  p1_t        p1i;
  nibble_t    p1o;
  logic       idl;

  byte_t       pad_model [PAD_CNT];          // what the console wrote to the pads
  byte_t       pkt_model [PKT_BYTES];        // bytes sent over the select lines
  pixel_t      pix_mem [LINES][ROW_PIX];     // pixels streamed into row 0
  pad_id_t     id_model;
  pad_id_t     mask_model;
  logic [1:0]  edge_div;
  int unsigned cycle_cnt = 0;

  icd2_top #(.ROW_BYTES(512)) i_dut (
    .CLK             (CLK),
    .cpu_ireset_r    (cpu_ireset_r),
    .snes_rd_start   (snes_rd_start),
    .snes_wr_end     (snes_wr_end),
    .snes_addr       (snes_addr),
    .data_in         (data_in),
    .data_out        (data_out),
    .cpu_rst         (cpu_rst),
    .ppu_dot_edge    (ppu_dot_edge),
    .ppu_pixel_valid (ppu_pixel_valid),
    .ppu_pixel       (ppu_pixel),
    .ppu_vsync_edge  (ppu_vsync_edge),
    .ppu_hsync_edge  (ppu_hsync_edge),
    .cpu_edge        (cpu_edge),
    .p1i             (p1i),
    .p1o             (p1o),
    .idl             (idl)
  );

  // ----------------------------------------------------------------------
  // clock, handheld cpu strobe, timeout
  // ----------------------------------------------------------------------
  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;  // 100 ns period
  end

  initial begin
    cpu_edge = 1'b0;
    edge_div = '0;
    forever begin
      @(posedge CLK);
      #10;
      cpu_edge = (edge_div == 2'd3);  // one strobe per 4 cycles
      edge_div = edge_div + 2'd1;
    end
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("*** FAILED ***");
      $fatal(1, "timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  // ----------------------------------------------------------------------
  // reference model and checker
  // ----------------------------------------------------------------------
  // planar byte at a row address: [8:4] tile, [3:1] line, [0] plane
  function automatic byte_t expected_row_byte(input int addr);
    int    tile;
    int    line;
    int    plane;
    byte_t val;
    tile  = addr / 16;
    line  = (addr / 2) % 8;
    plane = addr % 2;
    val   = '0;
    for (int k = 0; k < 8; k++) begin
      val[7 - k] = pix_mem[line][tile * 8 + k][plane];  // leftmost pixel in msb
    end
    return val;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("*** FAILED ***");
      $fatal(1, "Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
             $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // drivers, all called at 10 ns after a rising edge
  // ----------------------------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #10;
    end
  endtask

  task automatic bus_write(input logic [15:0] off, input byte_t val);
    snes_addr   = {8'h00, off};
    data_in     = val;
    snes_wr_end = 1'b1;
    wait_cycles(1);
    snes_wr_end = 1'b0;
    wait_cycles(2);  // keeps row data reads 3 cycles apart
  endtask

  task automatic bus_read(input logic [15:0] off, output byte_t val);
    snes_addr     = {8'h00, off};
    snes_rd_start = 1'b1;
    wait_cycles(1);
    snes_rd_start = 1'b0;
    wait_cycles(2);
    val = data_out;  // held until the next read
  endtask

  task automatic read_check(input logic [15:0] off, input byte_t exp, input string what);
    byte_t val;
    bus_read(off, val);
    check(32'(val), 32'(exp), what);
  endtask

  // new select value, returns once a cpu strobe has sampled it
  task automatic set_p1(input p1_t val);
    p1i = val;
    @(posedge CLK);
    while (cpu_edge !== 1'b1) @(posedge CLK);
    #10;
  endtask

  task automatic send_dot(input logic valid, input pixel_t pix, input logic vs, input logic hs);
    ppu_dot_edge    = 1'b1;
    ppu_pixel_valid = valid;
    ppu_pixel       = pix;
    ppu_vsync_edge  = vs;
    ppu_hsync_edge  = hs;
    wait_cycles(1);
    ppu_dot_edge    = 1'b0;
    ppu_pixel_valid = 1'b0;
    ppu_vsync_edge  = 1'b0;
    ppu_hsync_edge  = 1'b0;
    wait_cycles(3);  // dots 4 cycles apart
  endtask

  // 10, 01, then 11 which moves to the next player
  task automatic step_player();
    set_p1(2'b10);
    check(32'(p1o), 32'(pad_model[id_model][3:0]), "d-pad nibble");
    set_p1(2'b01);
    check(32'(p1o), 32'(pad_model[id_model][7:4]), "button nibble");
    set_p1(2'b11);
    id_model = (id_model + 2'd1) & mask_model;
    check(32'(p1o), 32'(4'd15 - 4'(id_model)), "player id answer");
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    bit bit_val;
    cpu_ireset_r    = 1'b1;
    snes_rd_start   = 1'b0;
    snes_wr_end     = 1'b0;
    snes_addr       = '0;
    data_in         = '0;
    ppu_dot_edge    = 1'b0;
    ppu_pixel_valid = 1'b0;
    ppu_pixel       = '0;
    ppu_vsync_edge  = 1'b0;
    ppu_hsync_edge  = 1'b0;
    p1i             = 2'b11;  // lines idle high
    void'($urandom(88881));
    repeat (16) @(posedge CLK);
    #10;
    cpu_ireset_r = 1'b0;
    set_p1(2'b11);  // let the first strobe see the idle lines

    // reset values
    check(32'(idl), 32'(1), "idl after reset");
    check(32'(cpu_rst), 32'(1), "cpu_rst after reset");
    read_check(REG_VER, 8'h61, "version");
    read_check(REG_PKTRDY, 8'h00, "packet ready after reset");
    bus_write(REG_CTL, 8'h80 | 8'h30);  // run, four players
    check(32'(cpu_rst), 32'(0), "cpu_rst after control write");

    // joypad answers, four players then two
    mask_model = 2'd3;
    id_model   = '0;
    for (int i = 0; i < PAD_CNT; i++) begin
      pad_model[i] = 8'($urandom);
      bus_write(REG_PAD0 + 16'(i), pad_model[i]);
    end
    check(32'(p1o), 32'(4'hF), "player 0 id answer");
    repeat (5) step_player();  // ids 1,2,3,0,1
    bus_write(REG_CTL, 8'h90);
    mask_model = 2'd1;
    repeat (4) step_player();  // ids 0,1,0,1

    // serial packet, lsb first per byte
    for (int i = 0; i < PKT_BYTES; i++) pkt_model[i] = 8'($urandom);
    set_p1(2'b00);
    check(32'(idl), 32'(0), "idl at packet start");
    set_p1(2'b11);
    for (int n = 0; n < PKT_BITS; n++) begin
      bit_val = pkt_model[n / 8][n % 8];
      set_p1(bit_val ? 2'b01 : 2'b10);
      set_p1(2'b11);
      check(32'(idl), 32'(0), $sformatf("idl during packet bit %0d", n));
    end
    set_p1(2'b10);  // terminator
    check(32'(idl), 32'(1), "idl after packet");
    read_check(REG_PKTRDY, 8'h01, "packet ready after packet");
    for (int i = 0; i < PKT_BYTES; i++) begin
      read_check(REG_PKT_BASE + 16'(i), pkt_model[i], $sformatf("packet byte %0d", i));
    end
    read_check(REG_PKTRDY, 8'h00, "packet ready after 7000 read");

    // aborted packet, 01 where 11 is due
    set_p1(2'b00);
    check(32'(idl), 32'(0), "idl at aborted packet start");
    set_p1(2'b01);
    check(32'(idl), 32'(1), "idl after abort");
    set_p1(2'b11);
    read_check(REG_PKTRDY, 8'h00, "packet ready after abort");

    // one character row of pixels into row buffer 0
    for (int l = 0; l < LINES; l++) begin
      for (int x = 0; x < ROW_PIX; x++) pix_mem[l][x] = 2'($urandom);
    end
    for (int l = 0; l < LINES; l++) begin
      for (int x = 0; x < ROW_PIX; x++) send_dot(1'b1, pix_mem[l][x], 1'b0, 1'b0);
      send_dot(1'b0, 2'b00, 1'b0, 1'b1);  // hsync
    end
    read_check(REG_LCDCHW, {5'd1, 1'b0, 2'd1}, "status after 8 lines");
    bus_write(REG_LCDCHR, 8'h00);
    for (int a = 0; a < TILES * 16; a++) begin
      read_check(REG_CHDAT, expected_row_byte(a), $sformatf("row 0 byte %0d", a));
    end

    // vsync clears the char row, write row stays
    send_dot(1'b0, 2'b00, 1'b1, 1'b0);
    read_check(REG_LCDCHW, {5'd0, 1'b0, 2'd1}, "status after vsync");

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== build.f ====
hw/icd2_pkg.sv
hw/row_buffers.sv
hw/pixel_packer.sv
hw/joypad_serial.sv
hw/icd2_regs.sv
hw/icd2_top.sv
tb/icd2_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module icd2_tb -f build.f -o icd2_sim \
  && ./obj_dir/icd2_sim \
  || exit 1
